//--- dmm_fpga_params.svh
/* widths, register count and spi frame lengths for the dmm front-end fpga
   include ahead of any module that sizes its ports from these */
`ifndef DMM_FPGA_PARAMS_SVH
`define DMM_FPGA_PARAMS_SVH

// spi register bank
`define REG_W          32       // every register is a full word
`define ADDR_W         8        // address byte leads each frame
`define REG_N          12       // status plus eleven writable
`define SPI_FRAME_BITS 40       // address byte then one register

// acquisition sequencer
`define SEQ_W          6        // azmux in 3:0, pc_sw in 5:4
`define SEQ_MAX        4        // sample words in one sequence

// precharge and aperture counters
`define CNT_W          24

// board pin word after mode select
`define PIN_W          24

// fixed low byte of the status word
`define STATUS_MAGIC   8'hAA

`endif

//--- dmm_fpga_pkg.sv
/* shared enums for the dmm front-end fpga
   compiled before every module that imports it */
package dmm_fpga_pkg;

  // output mode, low three bits of REG_MODE
  typedef enum logic [2:0] {
    MODE_DIRECT  = 3'd0,   // pins follow REG_DIRECT
    MODE_PATTERN = 3'd3,   // free running count, board bring-up
    MODE_SA_MOCK = 3'd6    // sequencer driving the mocked adc
  } mode_t;

  // spi register map
  typedef enum logic [7:0] {
    REG_STATUS       = 8'd0,    // read only
    REG_SPI_MUX      = 8'd1,    // one-hot peripheral select
    REG_4094         = 8'd2,    // bit 0 is the 4094 oe
    REG_MODE         = 8'd3,
    REG_DIRECT       = 8'd4,
    REG_SA_PRECHARGE = 8'd5,    // precharge clk count
    REG_SA_SEQ_N     = 8'd6,
    REG_SA_SEQ0      = 8'd7,
    REG_SA_SEQ1      = 8'd8,
    REG_SA_SEQ2      = 8'd9,
    REG_SA_SEQ3      = 8'd10,
    REG_ADC_APERTURE = 8'd11    // aperture clk count
  } reg_addr_t;

  typedef enum logic [1:0] {SA_IDLE, SA_PRECHARGE, SA_SAMPLE} sa_state_t;

  typedef enum logic {ADC_IDLE, ADC_APERTURE} adc_state_t;

endpackage

//--- spi_reg_bank.sv
/* spi slave register bank, oversampled on clk, with status read-back
   and routing of the shared spi lines to the selected peripheral */
`timescale 1ns/1ns
`include "dmm_fpga_params.svh"

module spi_reg_bank (
  input  logic                 clk,
  input  logic                 reset_i,
  // spi pins, mode 0, msb first
  input  logic                 sck_i,
  input  logic                 ss_i,                // active lo
  input  logic                 sdi_i,
  input  logic                 cs2_i,               // second chip select
  output logic                 sdo_o,
  input  logic [3:0]           hw_flags_i,
  input  logic [2:0]           sample_idx_last_i,
  // routed spi lines
  output logic                 spi_glb_clk_o,
  output logic                 spi_glb_mosi_o,
  output logic                 spi_4094_strobe_o,   // active hi
  output logic                 spi_4094_oe_o,
  output logic                 dac_ss_o,            // active lo
  output logic                 iso_dac_cs_o,        // active lo
  output logic                 iso_dac_cs2_o,       // active lo
  // register levels
  output dmm_fpga_pkg::mode_t  mode_o,
  output logic [`PIN_W-1:0]    direct_o,
  output logic [2:0]           seq_n_o,
  output logic [`SEQ_W-1:0]    seq0_o,
  output logic [`SEQ_W-1:0]    seq1_o,
  output logic [`SEQ_W-1:0]    seq2_o,
  output logic [`SEQ_W-1:0]    seq3_o,
  output logic [`CNT_W-1:0]    precharge_cnt_o,
  output logic [`CNT_W-1:0]    aperture_cnt_o
);
  import dmm_fpga_pkg::*;

  localparam int CNT_BITS = $clog2(`SPI_FRAME_BITS + 1);

  ////////////////////////////////////////////////////////////////////////////
  // pin sync and edge detect

  logic [2:0]          sck_sync;     // bit 2 is the previous sample
  logic [2:0]          ss_sync;
  logic [1:0]          sdi_sync;
  logic                sck_rise;
  logic                sck_fall;
  logic                ss_low;
  logic                ss_rise;      // end of frame
  logic                sdi_s;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sck_sync <= '0;
      ss_sync  <= '1;                // deselected
    end else begin
      sck_sync <= {sck_sync[1:0], sck_i};
      ss_sync  <= {ss_sync[1:0], ss_i};
    end
  end

  always_ff @(posedge clk) begin
    sdi_sync <= {sdi_sync[0], sdi_i};
  end

  assign sck_rise = sck_sync[1] & ~sck_sync[2];   // sample edge
  assign sck_fall = ~sck_sync[1] & sck_sync[2];   // launch edge
  assign ss_low   = ~ss_sync[1];
  assign ss_rise  = ss_sync[1] & ~ss_sync[2];
  assign sdi_s    = sdi_sync[1];

  ////////////////////////////////////////////////////////////////////////////
  // frame shift

  logic [CNT_BITS-1:0] bit_cnt;
  logic                frame_over;   // extra sck edges seen, frame dropped
  logic [`REG_W-1:0]   rx_sr;
  logic [`REG_W-1:0]   tx_sr;
  logic [`REG_W-1:0]   rd_val;
  logic [`ADDR_W-1:0]  addr_now;     // address as the 8th bit lands
  reg_addr_t           addr_q;

  always_ff @(posedge clk) begin
    if (reset_i || !ss_low) begin
      bit_cnt    <= '0;
      frame_over <= 1'b0;
    end else if (sck_rise) begin
      if (bit_cnt == CNT_BITS'(`SPI_FRAME_BITS)) begin
        frame_over <= 1'b1;          // counter holds at frame length
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign addr_now = {rx_sr[`ADDR_W-2:0], sdi_s};

  always_ff @(posedge clk) begin
    if (ss_low && sck_rise) begin
      rx_sr <= {rx_sr[`REG_W-2:0], sdi_s};
      if (bit_cnt == CNT_BITS'(`ADDR_W - 1)) begin
        addr_q <= reg_addr_t'(addr_now);
        tx_sr  <= rd_val;            // snapshot for the data phase
      end
    end else if (ss_low && sck_fall && bit_cnt > CNT_BITS'(`ADDR_W)) begin
      tx_sr <= {tx_sr[`REG_W-2:0], 1'b0};
    end
  end

  assign sdo_o = tx_sr[`REG_W-1];

  ////////////////////////////////////////////////////////////////////////////
  // register file and status

  logic [`REG_W-1:0]   regs [1:`REG_N-1];   // address 0 is the status word
  logic [`REG_W-1:0]   spi_mux;
  logic [`REG_W-1:0]   status;
  logic                wr_en;

  // only a full 40 bit frame to a writable address commits
  assign wr_en = ss_rise && !frame_over && bit_cnt == CNT_BITS'(`SPI_FRAME_BITS)
              && addr_q != REG_STATUS && addr_q < `REG_N;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 1; i < `REG_N; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[addr_q[3:0]] <= rx_sr;
    end
  end

  assign spi_mux = regs[4'(REG_SPI_MUX)];
  assign status  = {9'b0, seq_n_o, 1'b0, sample_idx_last_i, spi_mux[3:0],
                    hw_flags_i, `STATUS_MAGIC};

  always_comb begin
    rd_val = '0;                     // unknown address reads zero
    if (addr_now == REG_STATUS) begin
      rd_val = status;
    end else if (addr_now < `REG_N) begin
      rd_val = regs[addr_now[3:0]];
    end
  end

  // register levels out to the sequencer and mode select
  assign spi_4094_oe_o   = regs[4'(REG_4094)][0];   // lo at start up
  assign mode_o          = mode_t'(regs[4'(REG_MODE)][2:0]);
  assign direct_o        = regs[4'(REG_DIRECT)][`PIN_W-1:0];
  assign precharge_cnt_o = regs[4'(REG_SA_PRECHARGE)][`CNT_W-1:0];
  assign seq_n_o         = regs[4'(REG_SA_SEQ_N)][2:0];
  assign seq0_o          = regs[4'(REG_SA_SEQ0)][`SEQ_W-1:0];
  assign seq1_o          = regs[4'(REG_SA_SEQ1)][`SEQ_W-1:0];
  assign seq2_o          = regs[4'(REG_SA_SEQ2)][`SEQ_W-1:0];
  assign seq3_o          = regs[4'(REG_SA_SEQ3)][`SEQ_W-1:0];
  assign aperture_cnt_o  = regs[4'(REG_ADC_APERTURE)][`CNT_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // spi routing, straight from the pins

  assign spi_glb_clk_o     = (spi_mux == '0) ? 1'b1 : sck_i;     // park hi
  assign spi_glb_mosi_o    = (spi_mux == '0) ? 1'b1 : sdi_i;     // park hi
  assign spi_4094_strobe_o = (spi_mux == 32'd1) ? ~cs2_i : 1'b0; // park lo
  assign dac_ss_o          = (spi_mux == 32'd2) ? cs2_i : 1'b1;
  assign iso_dac_cs_o      = (spi_mux == 32'd4) ? cs2_i : 1'b1;
  assign iso_dac_cs2_o     = (spi_mux == 32'd8) ? cs2_i : 1'b1;

  // counter saturates at frame length however many sck edges arrive
  bit_cnt_bound_a: assert property (@(posedge clk) disable iff (reset_i)
    ss_low |-> bit_cnt <= CNT_BITS'(`SPI_FRAME_BITS));

endmodule

//--- acq_sequencer.sv
/* precharge and autozero acquisition sequencer over up to four sample words
   runs while trig_i is high and hands each aperture to the adc */
`timescale 1ns/1ns
`include "dmm_fpga_params.svh"

module acq_sequencer (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    trig_i,        // lo holds idle
  input  logic [2:0]              seq_n_i,
  input  logic [`SEQ_W-1:0]       seq0_i,
  input  logic [`SEQ_W-1:0]       seq1_i,
  input  logic [`SEQ_W-1:0]       seq2_i,
  input  logic [`SEQ_W-1:0]       seq3_i,
  input  logic [`CNT_W-1:0]       precharge_cnt_i,
  input  logic                    adc_valid_i,   // one cycle, aperture done
  output logic [1:0]              pc_sw_o,
  output logic [3:0]              azmux_o,
  output logic                    adc_start_o,
  output logic                    adc_reset_n_o,
  output logic                    meas_done_o,
  output logic [2:0]              sample_idx_last_o,
  output dmm_fpga_pkg::sa_state_t state_o
);
  import dmm_fpga_pkg::*;

  logic [`SEQ_W-1:0] words [`SEQ_MAX];
  logic [1:0]        idx;          // sample k
  logic [1:0]        idx_max;      // clamped seq_n minus one
  logic [1:0]        idx_next;
  logic [`CNT_W-1:0] pc_cnt;

  assign words = '{seq0_i, seq1_i, seq2_i, seq3_i};

  // seq_n of 0 runs one word, anything above 4 runs four
  always_comb begin
    if (seq_n_i == 3'd0) begin
      idx_max = 2'd0;
    end else if (seq_n_i > 3'd`SEQ_MAX) begin
      idx_max = 2'd3;
    end else begin
      idx_max = 2'(seq_n_i - 3'd1);
    end
    idx_next = (idx >= idx_max) ? 2'd0 : idx + 2'd1;   // also recovers if seq_n shrinks
  end

  always_ff @(posedge clk) begin
    if (reset_i || !trig_i) begin
      state_o           <= SA_IDLE;
      idx               <= '0;
      pc_cnt            <= '0;
      pc_sw_o           <= '0;
      azmux_o           <= '0;
      adc_start_o       <= 1'b0;
      adc_reset_n_o     <= 1'b0;   // adc held in reset
      meas_done_o       <= 1'b0;
      sample_idx_last_o <= '0;
    end else begin
      adc_start_o <= 1'b0;         // strobes
      meas_done_o <= 1'b0;
      case (state_o)
        SA_IDLE: begin
          state_o <= SA_PRECHARGE;
          azmux_o <= words[idx][3:0];
          pc_cnt  <= '0;
        end
        SA_PRECHARGE: begin
          // azmux settles on word k with pc_sw open
          if (pc_cnt == precharge_cnt_i) begin
            state_o       <= SA_SAMPLE;
            pc_sw_o       <= words[idx][5:4];
            adc_reset_n_o <= 1'b1;
            adc_start_o   <= 1'b1;
          end else begin
            pc_cnt <= pc_cnt + 1'b1;
          end
        end
        SA_SAMPLE: begin
          if (adc_valid_i) begin
            sample_idx_last_o <= {1'b0, idx};
            meas_done_o       <= 1'b1;
            idx               <= idx_next;
            azmux_o           <= words[idx_next][3:0];   // next precharge
            pc_sw_o           <= '0;
            adc_reset_n_o     <= 1'b0;
            pc_cnt            <= '0;
            state_o           <= SA_PRECHARGE;
          end
        end
        default: state_o <= SA_IDLE;
      endcase
    end
  end

  // adc start only on the precharge to sample transition
  start_on_entry_a: assert property (@(posedge clk) disable iff (reset_i)
    adc_start_o |-> state_o == SA_SAMPLE && $past(state_o) == SA_PRECHARGE);

endmodule

//--- adc_mock.sv
/* stand-in for the charge-balance adc
   times the aperture after start_i and pulses valid_o once */
`timescale 1ns/1ns
`include "dmm_fpga_params.svh"

module adc_mock (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              reset_n_i,       // lo holds idle
  input  logic              start_i,
  input  logic [`CNT_W-1:0] aperture_cnt_i,
  output logic              valid_o
);
  import dmm_fpga_pkg::*;

  adc_state_t        state;
  logic [`CNT_W-1:0] ap_cnt;

  always_ff @(posedge clk) begin
    if (reset_i || !reset_n_i) begin
      state   <= ADC_IDLE;
      ap_cnt  <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      case (state)
        ADC_IDLE: begin
          if (start_i) begin
            state  <= ADC_APERTURE;
            ap_cnt <= '0;
          end
        end
        default: begin
          // aperture_cnt_i+1 cycles in here
          if (ap_cnt == aperture_cnt_i) begin
            valid_o <= 1'b1;
            state   <= ADC_IDLE;
          end else begin
            ap_cnt <= ap_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  valid_single_a: assert property (@(posedge clk) disable iff (reset_i)
    valid_o |=> !valid_o);

endmodule

//--- output_mode_sel.sv
/* selects what drives the 24 board pin bits by output mode
   registered, one cycle from inputs to pins_o */
`timescale 1ns/1ns
`include "dmm_fpga_params.svh"

module output_mode_sel (
  input  logic                    clk,
  input  logic                    reset_i,
  input  dmm_fpga_pkg::mode_t     mode_i,
  input  logic [`PIN_W-1:0]       direct_i,
  input  logic [1:0]              pc_sw_i,
  input  logic [3:0]              azmux_i,
  input  dmm_fpga_pkg::sa_state_t sa_state_i,
  input  logic [2:0]              sample_idx_i,
  input  logic                    adc_reset_n_i,
  input  logic                    meas_done_i,
  output logic [`PIN_W-1:0]       pins_o
);
  import dmm_fpga_pkg::*;

  logic [`PIN_W-1:0] pattern;     // free running, needs only the xtal
  logic [`PIN_W-1:0] pins_d;
  logic [3:0]        sa_leds;
  logic [7:0]        sa_monitor;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pattern <= '0;
    end else begin
      pattern <= pattern + 1'b1;
    end
  end

  assign sa_leds    = {sa_state_i != SA_IDLE, sample_idx_i};   // top led is trig
  assign sa_monitor = {4'b0, meas_done_i, adc_reset_n_i, sa_state_i};

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  pins_d = direct_i;
      MODE_PATTERN: pins_d = pattern;
      MODE_SA_MOCK: pins_d = {meas_done_i,    // 23 spi interrupt
                              1'b0,           // 22 cmpr latch
                              4'b0,           // 18 adc refmux
                              azmux_i,        // 14
                              pc_sw_i,        // 12
                              sa_monitor,     // 4
                              sa_leds};       // 0
      default:      pins_d = '0;              // unused modes all lo
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pins_o <= '0;
    end else begin
      pins_o <= pins_d;
    end
  end

endmodule

//--- dmm_fpga_top.sv
/* top level of the dmm front-end fpga
   spi bank, sequencer, adc mock and output mode select wired to the pins */
`timescale 1ns/1ns
`include "dmm_fpga_params.svh"

module dmm_fpga_top (
  input  logic       clk,
  input  logic       reset_i,
  // spi from the mcu
  input  logic       sck_i,
  input  logic       ss_i,
  input  logic       sdi_i,
  output logic       sdo_o,
  input  logic       cs2_i,
  input  logic [3:0] hw_flags_i,
  input  logic       trig_sa_i,
  // routed spi
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_4094_oe_o,
  output logic       dac_ss_o,
  output logic       iso_dac_cs_o,
  output logic       iso_dac_cs2_o,
  // board pins
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,          // precharge switches
  output logic [3:0] azmux_o,
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_o,
  output logic       spi_interrupt_o,
  output logic       unused_o
);
  import dmm_fpga_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // bank levels

  mode_t             mode;
  logic [`PIN_W-1:0] direct;
  logic [2:0]        seq_n;
  logic [`SEQ_W-1:0] seq0;
  logic [`SEQ_W-1:0] seq1;
  logic [`SEQ_W-1:0] seq2;
  logic [`SEQ_W-1:0] seq3;
  logic [`CNT_W-1:0] precharge_cnt;
  logic [`CNT_W-1:0] aperture_cnt;

  // sequencer and adc mock
  logic [1:0]        sa_pc_sw;
  logic [3:0]        sa_azmux;
  logic              adc_start;
  logic              adc_reset_n;
  logic              adc_valid;
  logic              meas_done;
  logic [2:0]        sample_idx_last;   // also into the status word
  sa_state_t         sa_state;
  logic [`PIN_W-1:0] pins;

  spi_reg_bank u_spi_reg_bank (
    .clk               (clk),
    .reset_i           (reset_i),
    .sck_i             (sck_i),
    .ss_i              (ss_i),
    .sdi_i             (sdi_i),
    .cs2_i             (cs2_i),
    .sdo_o             (sdo_o),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .spi_glb_clk_o     (spi_glb_clk_o),
    .spi_glb_mosi_o    (spi_glb_mosi_o),
    .spi_4094_strobe_o (spi_4094_strobe_o),
    .spi_4094_oe_o     (spi_4094_oe_o),
    .dac_ss_o          (dac_ss_o),
    .iso_dac_cs_o      (iso_dac_cs_o),
    .iso_dac_cs2_o     (iso_dac_cs2_o),
    .mode_o            (mode),
    .direct_o          (direct),
    .seq_n_o           (seq_n),
    .seq0_o            (seq0),
    .seq1_o            (seq1),
    .seq2_o            (seq2),
    .seq3_o            (seq3),
    .precharge_cnt_o   (precharge_cnt),
    .aperture_cnt_o    (aperture_cnt)
  );

  acq_sequencer u_acq_sequencer (
    .clk               (clk),
    .reset_i           (reset_i),
    .trig_i            (trig_sa_i),
    .seq_n_i           (seq_n),
    .seq0_i            (seq0),
    .seq1_i            (seq1),
    .seq2_i            (seq2),
    .seq3_i            (seq3),
    .precharge_cnt_i   (precharge_cnt),
    .adc_valid_i       (adc_valid),
    .pc_sw_o           (sa_pc_sw),
    .azmux_o           (sa_azmux),
    .adc_start_o       (adc_start),
    .adc_reset_n_o     (adc_reset_n),
    .meas_done_o       (meas_done),
    .sample_idx_last_o (sample_idx_last),
    .state_o           (sa_state)
  );

  adc_mock u_adc_mock (
    .clk            (clk),
    .reset_i        (reset_i),
    .reset_n_i      (adc_reset_n),
    .start_i        (adc_start),
    .aperture_cnt_i (aperture_cnt),
    .valid_o        (adc_valid)
  );

  output_mode_sel u_output_mode_sel (
    .clk           (clk),
    .reset_i       (reset_i),
    .mode_i        (mode),
    .direct_i      (direct),
    .pc_sw_i       (sa_pc_sw),
    .azmux_i       (sa_azmux),
    .sa_state_i    (sa_state),
    .sample_idx_i  (sample_idx_last),
    .adc_reset_n_i (adc_reset_n),
    .meas_done_i   (meas_done),
    .pins_o        (pins)
  );

  ////////////////////////////////////////////////////////////////////////////
  // pin word onto the board

  assign {spi_interrupt_o, adc_cmpr_latch_o, adc_refmux_o, azmux_o,
          pc_sw_o, monitor_o, leds_o} = pins;

  assign unused_o = 1'b1;   // keeps the isolator input from floating

endmodule

//--- tb_clock_gen.sv
/* free running clock for the testbench, 4 ns period */
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int HALF_NS = 2            // half period
) (
  output logic clk_o
);
  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_NS);
      clk_o = ~clk_o;
    end
  end

endmodule

//--- tb_dmm_fpga.sv
/* testbench for the dmm front-end top level with spi master tasks and a register model
   runs random register, status, routing, direct, pattern and sequencer checks */
`timescale 1ns/1ns
`include "dmm_fpga_params.svh"

module tb_dmm_fpga;
  import dmm_fpga_pkg::*;

  localparam int HALF_BIT   = 4;       // clk cycles per sck level
  localparam int PULSE_WAIT = 2000;    // longest gap between two samples

  logic        clk;
  logic        reset_i;
  logic        sck;
  logic        ss;
  logic        sdi;
  logic        cs2;
  logic [3:0]  hw_flags;
  logic        trig_sa;
  logic        sdo;
  logic        spi_glb_clk;
  logic        spi_glb_mosi;
  logic        spi_4094_strobe;
  logic        spi_4094_oe;
  logic        dac_ss;
  logic        iso_dac_cs;
  logic        iso_dac_cs2;
  logic [3:0]  leds;
  logic [7:0]  monitor;
  logic [1:0]  pc_sw;
  logic [3:0]  azmux;
  logic [3:0]  adc_refmux;
  logic        cmpr_latch;
  logic        spi_interrupt;
  logic        unused;

  logic [`REG_W-1:0] model [`REG_N];   // shadow of the register file
  integer      seed;
  int          mismatches;
  int          timeouts;

  // sequencer tracking on the falling edge
  logic        seq_check_on;
  int          n_eff;                  // words per sequence after clamping
  int          k_next;                 // sample now running
  int          k_last;                 // sample just completed
  int          pulse_cnt;
  logic [3:0]  prev_azmux;

  tb_clock_gen u_clock_gen (.clk_o(clk));

  dmm_fpga_top dut (
    .clk               (clk),
    .reset_i           (reset_i),
    .sck_i             (sck),
    .ss_i              (ss),
    .sdi_i             (sdi),
    .sdo_o             (sdo),
    .cs2_i             (cs2),
    .hw_flags_i        (hw_flags),
    .trig_sa_i         (trig_sa),
    .spi_glb_clk_o     (spi_glb_clk),
    .spi_glb_mosi_o    (spi_glb_mosi),
    .spi_4094_strobe_o (spi_4094_strobe),
    .spi_4094_oe_o     (spi_4094_oe),
    .dac_ss_o          (dac_ss),
    .iso_dac_cs_o      (iso_dac_cs),
    .iso_dac_cs2_o     (iso_dac_cs2),
    .leds_o            (leds),
    .monitor_o         (monitor),
    .pc_sw_o           (pc_sw),
    .azmux_o           (azmux),
    .adc_refmux_o      (adc_refmux),
    .adc_cmpr_latch_o  (cmpr_latch),
    .spi_interrupt_o   (spi_interrupt),
    .unused_o          (unused)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one spi mode 0 frame msb first with sdo sampled in each low phase
  task automatic spi_frame(input logic [7:0] addr, input logic [31:0] wdata,
                           input int nbits, output logic [31:0] rdata);
    logic [40:0] frame;
    frame = {addr, wdata, 1'b0};
    rdata = '0;
    @(posedge clk);
    ss <= 1'b0;
    wait_cycles(HALF_BIT);
    for (int i = 0; i < nbits; i++) begin
      sdi <= frame[40 - i];              // sck is low here
      wait_cycles(HALF_BIT);
      @(negedge clk);
      if (i >= `ADDR_W && i < `SPI_FRAME_BITS) begin
        rdata = {rdata[30:0], sdo};
      end
      @(posedge clk);
      sck <= 1'b1;
      wait_cycles(HALF_BIT);
      sck <= 1'b0;
    end
    wait_cycles(HALF_BIT);
    ss <= 1'b1;
    wait_cycles(2 * HALF_BIT);           // commit lands in here
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] ignored;
    spi_frame(addr, data, `SPI_FRAME_BITS, ignored);
    if (addr != 8'(REG_STATUS) && addr < 8'(`REG_N)) begin
      model[addr[3:0]] = data;
    end
  endtask

  // one bit past the frame length so the bank drops the write
  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    spi_frame(addr, 32'h0, `SPI_FRAME_BITS + 1, data);
  endtask

  function automatic logic [31:0] status_word(input logic [3:0] flags,
                                              input logic [2:0] idx);
    status_word = {9'b0, model[6][2:0], 1'b0, idx, model[1][3:0], flags,
                   `STATUS_MAGIC};
  endfunction

  function automatic logic [23:0] pin_word();
    pin_word = {spi_interrupt, cmpr_latch, adc_refmux, azmux, pc_sw, monitor, leds};
  endfunction

  task automatic check_routing(input logic [31:0] mux);
    logic [31:0] rnd;
    for (int c = 0; c < 4; c++) begin
      rnd = $random(seed);
      @(posedge clk);
      cs2 <= c[0];
      sck <= c[1];                       // ss stays high so the bank ignores it
      sdi <= rnd[0];
      wait_cycles(2);
      @(negedge clk);
      compare_value("spi_glb_clk", 32'(spi_glb_clk), 32'((mux == 0) ? 1'b1 : c[1]));
      compare_value("spi_glb_mosi", 32'(spi_glb_mosi), 32'((mux == 0) ? 1'b1 : rnd[0]));
      compare_value("4094 strobe", 32'(spi_4094_strobe), 32'((mux == 1) ? !c[0] : 1'b0));
      compare_value("4094 oe", 32'(spi_4094_oe), 32'(model[2][0]));
      compare_value("dac_ss", 32'(dac_ss), 32'((mux == 2) ? c[0] : 1'b1));
      compare_value("iso_dac_cs", 32'(iso_dac_cs), 32'((mux == 4) ? c[0] : 1'b1));
      compare_value("iso_dac_cs2", 32'(iso_dac_cs2), 32'((mux == 8) ? c[0] : 1'b1));
    end
    @(posedge clk);
    sck <= 1'b0;
    cs2 <= 1'b1;
  endtask

  task automatic wait_pulse(input int target, output logic ok);
    int cyc;
    cyc = 0;
    while (pulse_cnt < target && cyc < PULSE_WAIT) begin
      @(posedge clk);
      cyc++;
    end
    ok = (pulse_cnt >= target);
    if (!ok) begin
      timeouts++;
      $display("Timeout at %0t ns: sequencer sample %0d never raised spi_interrupt",
               $time, target - 1);
    end
  endtask

  // word order and pc_sw during each sample
  always @(negedge clk) begin
    if (seq_check_on) begin
      if (spi_interrupt) begin
        compare_value("azmux before interrupt", 32'(prev_azmux),
                      32'(model[7 + k_next][3:0]));
        k_last    = k_next;
        k_next    = (k_next + 1) % n_eff;
        pulse_cnt++;
      end else if (monitor[1:0] == 2'(SA_SAMPLE)) begin
        compare_value("pc_sw in sample", 32'(pc_sw), 32'(model[7 + k_next][5:4]));
        compare_value("azmux in sample", 32'(azmux), 32'(model[7 + k_next][3:0]));
      end
      prev_azmux = azmux;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [31:0] mux_vals [6];
    logic [3:0]  flags_v;
    logic [11:0] pat_prev;
    logic [11:0] pat_now;
    logic [2:0]  other_mode;
    logic        ok;

    seed         = 32'ha8a15f4a;
    mismatches   = 0;
    timeouts     = 0;
    seq_check_on = 1'b0;
    n_eff        = 1;
    k_next       = 0;
    k_last       = 0;
    pulse_cnt    = 0;
    prev_azmux   = '0;
    for (int i = 0; i < `REG_N; i++) begin
      model[i] = '0;
    end
    reset_i  <= 1'b1;
    sck      <= 1'b0;
    ss       <= 1'b1;
    sdi      <= 1'b0;
    cs2      <= 1'b1;
    hw_flags <= '0;
    trig_sa  <= 1'b0;
    repeat (8) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    compare_value("pins after reset", 32'(pin_word()), 32'h0);

    // register access where a status write must not land
    for (int a = 1; a < `REG_N; a++) begin
      rnd = $random(seed);
      write_reg(8'(a), rnd);
    end
    rnd = $random(seed);
    write_reg(8'(REG_STATUS), rnd);
    for (int a = 1; a < `REG_N; a++) begin
      read_reg(8'(a), rd);
      compare_value($sformatf("reg %0d read back", a), rd, model[a]);
    end

    // status word before the sequencer has run
    flags_v = 4'($random(seed));
    @(posedge clk);
    hw_flags <= flags_v;
    read_reg(8'(REG_STATUS), rd);
    compare_value("status word", rd, status_word(flags_v, 3'd0));

    // spi routing per peripheral select
    rnd      = $random(seed);
    mux_vals = '{32'd0, 32'd1, 32'd2, 32'd4, 32'd8, rnd};
    for (int m = 0; m < 6; m++) begin
      write_reg(8'(REG_SPI_MUX), mux_vals[m]);
      check_routing(mux_vals[m]);
    end

    ////////////////////////////////////////////////////////////////////////////
    // direct mode then an unlisted mode

    rnd = $random(seed);
    write_reg(8'(REG_DIRECT), rnd);
    write_reg(8'(REG_MODE), 32'(MODE_DIRECT));
    wait_cycles(2);
    @(negedge clk);
    compare_value("direct leds", 32'(leds), 32'(model[4][3:0]));
    compare_value("direct monitor", 32'(monitor), 32'(model[4][11:4]));
    compare_value("direct pc_sw", 32'(pc_sw), 32'(model[4][13:12]));
    compare_value("direct azmux", 32'(azmux), 32'(model[4][17:14]));
    compare_value("direct refmux", 32'(adc_refmux), 32'(model[4][21:18]));
    compare_value("direct cmpr latch", 32'(cmpr_latch), 32'(model[4][22]));
    compare_value("direct interrupt", 32'(spi_interrupt), 32'(model[4][23]));
    compare_value("unused pin", 32'(unused), 32'd1);   // tied high

    rnd = $random(seed);
    case (rnd % 32'd5)
      0:       other_mode = 3'd1;
      1:       other_mode = 3'd2;
      2:       other_mode = 3'd4;
      3:       other_mode = 3'd5;
      default: other_mode = 3'd7;
    endcase
    write_reg(8'(REG_MODE), 32'(other_mode));
    wait_cycles(2);
    @(negedge clk);
    compare_value($sformatf("pins in mode %0d", other_mode), 32'(pin_word()), 32'h0);

    // pattern mode long enough to cross the 12 bit wrap
    write_reg(8'(REG_MODE), 32'(MODE_PATTERN));
    @(negedge clk);
    pat_prev = {monitor, leds};
    repeat (4200) begin
      @(negedge clk);
      pat_now  = {monitor, leds};
      pat_prev = pat_prev + 12'd1;       // wraps at 12 bits
      compare_value("pattern step", 32'(pat_now), 32'(pat_prev));
      pat_prev = pat_now;
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequencer with the mocked adc

    rnd = $random(seed);
    write_reg(8'(REG_SA_SEQ_N), 32'(rnd[2:0]));
    for (int w = 0; w < `SEQ_MAX; w++) begin
      rnd = $random(seed);
      write_reg(8'(REG_SA_SEQ0) + 8'(w), rnd);
    end
    rnd = $random(seed);
    // precharge outlasts a status read frame
    write_reg(8'(REG_SA_PRECHARGE), 32'd600 + 32'(rnd[5:0]));
    rnd = $random(seed);
    write_reg(8'(REG_ADC_APERTURE), 32'(rnd[3:0]));
    write_reg(8'(REG_MODE), 32'(MODE_SA_MOCK));
    if (model[6][2:0] == 3'd0) begin
      n_eff = 1;
    end else if (model[6][2:0] > 3'd4) begin
      n_eff = 4;                       // clamp to four words
    end else begin
      n_eff = int'(model[6][2:0]);
    end
    k_next    = 0;
    pulse_cnt = 0;
    @(posedge clk);
    trig_sa      <= 1'b1;
    seq_check_on = 1'b1;
    ok           = 1'b1;
    for (int s = 0; s < 8 && ok; s++) begin
      wait_pulse(s + 1, ok);
      if (ok) begin
        flags_v = 4'($random(seed));
        hw_flags <= flags_v;
        read_reg(8'(REG_STATUS), rd);
        compare_value("status after sample", rd, status_word(flags_v, 3'(k_last)));
      end
    end
    @(posedge clk);
    trig_sa      <= 1'b0;
    seq_check_on = 1'b0;

    $display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- dmm_fpga.f
+incdir+.
dmm_fpga_pkg.sv
spi_reg_bank.sv
acq_sequencer.sv
adc_mock.sv
output_mode_sel.sv
dmm_fpga_top.sv
tb_clock_gen.sv
tb_dmm_fpga.sv

//--- Makefile
# Verilator flow for the dmm front-end fpga
TB  = tb_dmm_fpga
BIN = obj_dir/V$(TB)

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f dmm_fpga.f --top-module dmm_fpga_top
	verilator --lint-only --timing --assert -f dmm_fpga.f --top-module $(TB)

# pass only when the testbench prints the pass line
sim:
	verilator --binary --timing --assert -f dmm_fpga.f --top-module $(TB)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
